// File: verilog/sms_pkg.sv
//////////////////////////////////////////////////
// sms bank shared definitions
// widths, AHB encodings and the deny FSM states
//////////////////////////////////////////////////

package sms_pkg;

  localparam int RAM_WORDS = 16384;

  typedef logic [31:0] haddr_t;
  typedef logic [31:0] hdata_t;
  // bits 1:0 pick the lane, bits 15:2 the word
  typedef logic [15:0] ram_addr_t;
  typedef logic [13:0] word_idx_t;
  typedef logic [3:0]  byte_en_t;

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_e;

  typedef enum logic [1:0] {
    HRESP_OKAY  = 2'b00,
    HRESP_ERROR = 2'b01
  } hresp_e;

  typedef enum logic [1:0] {
    DENY_IDLE   = 2'b00,
    DENY_FIRST  = 2'b01,
    DENY_SECOND = 2'b10
  } deny_state_e;

endpackage

// File: verilog/sms_deny_gate.sv
//////////////////////////////////////////////////
// sms region deny gate
// qualifies AHB transfers, blocks denied ones and
// answers them with a two-cycle ERROR response
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sms_deny_gate (
  input  logic             i_sys_hclk,
  input  logic             i_sys_rst_b,
  input  logic             i_hsel,
  input  sms_pkg::htrans_e i_htrans,
  input  logic             i_hwrite,
  input  logic             i_rd_deny,
  input  logic             i_wr_deny,
  input  logic             i_slv_hready,
  output logic             o_xfer,
  output logic             o_hready,
  output sms_pkg::hresp_e  o_hresp
);
  import sms_pkg::*;

  deny_state_e state_q;
  deny_state_e state_d;
  logic        act;
  logic        denied;

  // active transfer in the address phase
  assign act = i_hsel & ((i_htrans == HTRANS_NONSEQ) | (i_htrans == HTRANS_SEQ)) & o_hready;
  assign denied = act & (i_hwrite ? i_wr_deny : i_rd_deny);
  assign o_xfer = act & ~denied;

  always_comb
  begin
    state_d = DENY_IDLE;
    case (state_q)
      DENY_FIRST:
        state_d = DENY_SECOND;
      default:
        // hready is high in idle and second, so a new deny can start here
        state_d = denied ? DENY_FIRST : DENY_IDLE;
    endcase
  end

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
      state_q <= DENY_IDLE;
    else
      state_q <= state_d;
  end

  // error shape is low then high, otherwise the slave response
  assign o_hready = (state_q == DENY_FIRST)  ? 1'b0 :
                    (state_q == DENY_SECOND) ? 1'b1 : i_slv_hready;
  assign o_hresp  = (state_q == DENY_IDLE) ? HRESP_OKAY : HRESP_ERROR;

endmodule

// File: verilog/sms_ahb_slave.sv
//////////////////////////////////////////////////
// sms AHB slave stage
// defers writes to the data phase, replays a read
// that collides with a pending write
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sms_ahb_slave (
  input  logic                i_sys_hclk,
  input  logic                i_sys_rst_b,
  input  logic                i_xfer,
  input  sms_pkg::haddr_t     i_haddr,
  input  sms_pkg::hsize_e     i_hsize,
  input  logic                i_hwrite,
  output logic                o_hready,
  output logic                o_ram_sel,
  output logic                o_ram_write,
  output sms_pkg::hsize_e     o_ram_size,
  output sms_pkg::ram_addr_t  o_ram_addr,
  output logic                o_dphase,
  output sms_pkg::hsize_e     o_dp_size,
  output logic [1:0]          o_dp_lane,
  output logic                o_idle
);
  import sms_pkg::*;

  logic      wr_pend_q;
  logic      rd_replay_q;
  logic      dphase_q;
  ram_addr_t wr_addr_q;
  hsize_e    wr_size_q;
  ram_addr_t rd_addr_q;
  hsize_e    rd_size_q;
  hsize_e    dp_size_q;
  logic [1:0] dp_lane_q;
  logic      rd_conflict;

  // a fresh read while the RAM is busy with the deferred write
  assign rd_conflict = i_xfer & ~i_hwrite & wr_pend_q;

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
    begin
      wr_pend_q   <= 1'b0;
      rd_replay_q <= 1'b0;
      dphase_q    <= 1'b0;
    end
    else
    begin
      wr_pend_q   <= i_xfer & i_hwrite;
      rd_replay_q <= rd_conflict;
      if (o_hready)
        dphase_q <= i_xfer;
    end
  end

  always_ff @(posedge i_sys_hclk)
  begin
    if (i_xfer && i_hwrite)
    begin
      wr_addr_q <= i_haddr[15:0];
      wr_size_q <= i_hsize;
    end
    if (rd_conflict)
    begin
      rd_addr_q <= i_haddr[15:0];
      rd_size_q <= i_hsize;
    end
    if (o_hready && i_xfer)
    begin
      dp_size_q <= i_hsize;
      dp_lane_q <= i_haddr[1:0];
    end
  end

  // RAM request, deferred write first, then replayed read, then new read
  always_comb
  begin
    o_ram_sel   = 1'b0;
    o_ram_write = 1'b0;
    o_ram_size  = i_hsize;
    o_ram_addr  = i_haddr[15:0];
    if (wr_pend_q)
    begin
      o_ram_sel   = 1'b1;
      o_ram_write = 1'b1;
      o_ram_size  = wr_size_q;
      o_ram_addr  = wr_addr_q;
    end
    else if (rd_replay_q)
    begin
      o_ram_sel  = 1'b1;
      o_ram_size = rd_size_q;
      o_ram_addr = rd_addr_q;
    end
    else if (i_xfer && !i_hwrite)
      o_ram_sel = 1'b1;
  end

  // one wait state while the collided read is replayed
  assign o_hready  = ~rd_replay_q;
  assign o_dphase  = dphase_q;
  assign o_dp_size = dp_size_q;
  assign o_dp_lane = dp_lane_q;
  assign o_idle    = ~i_xfer & ~wr_pend_q & ~rd_replay_q;

endmodule

// File: verilog/sms_lane_swap.sv
//////////////////////////////////////////////////
// sms byte lane swap
// big-endian sub-word lane mapping, both ways
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sms_lane_swap (
  input  logic             i_big_endian_b,
  input  logic             i_dphase,
  input  sms_pkg::hsize_e  i_dp_size,
  input  logic [1:0]       i_dp_lane,
  input  sms_pkg::hdata_t  i_hwdata,
  input  sms_pkg::hdata_t  i_ram_rdata,
  output sms_pkg::hdata_t  o_ram_wdata,
  output sms_pkg::hdata_t  o_hrdata
);
  import sms_pkg::*;

  logic [1:0] lane_mir;

  // mirrored lane, 3 - k
  assign lane_mir = ~i_dp_lane;

  always_comb
  begin
    o_ram_wdata = i_hwdata;
    o_hrdata    = i_ram_rdata;
    if (!i_big_endian_b && i_dphase)
    begin
      case (i_dp_size)
        HSIZE_BYTE:
        begin
          o_ram_wdata = '0;
          o_hrdata    = '0;
          o_ram_wdata[{i_dp_lane, 3'b000} +: 8] = i_hwdata[{lane_mir, 3'b000} +: 8];
          o_hrdata[{lane_mir, 3'b000} +: 8]     = i_ram_rdata[{i_dp_lane, 3'b000} +: 8];
        end
        HSIZE_HALF:
        begin
          if (!i_dp_lane[1])
          begin
            o_ram_wdata = {16'h0000, i_hwdata[31:16]};
            o_hrdata    = {i_ram_rdata[15:0], 16'h0000};
          end
          else
          begin
            o_ram_wdata = {i_hwdata[15:0], 16'h0000};
            o_hrdata    = {16'h0000, i_ram_rdata[31:16]};
          end
        end
        default:
        begin
          // words keep their layout
          o_ram_wdata = i_hwdata;
          o_hrdata    = i_ram_rdata;
        end
      endcase
    end
  end

endmodule

// File: verilog/sms_sram_bank.sv
//////////////////////////////////////////////////
// sms sram bank
// byte enable decode and the 16k word array
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sms_sram_bank (
  input  logic                i_sys_hclk,
  input  logic                i_sys_rst_b,
  input  logic                i_ram_sel,
  input  logic                i_ram_write,
  input  sms_pkg::hsize_e     i_ram_size,
  input  sms_pkg::ram_addr_t  i_ram_addr,
  input  sms_pkg::hdata_t     i_ram_wdata,
  output sms_pkg::hdata_t     o_ram_rdata
);
  import sms_pkg::*;

  byte_en_t  byte_en;
  word_idx_t word_idx;
  hdata_t    mem [RAM_WORDS];
  hdata_t    rd_q;
  logic      sel_q;

  assign word_idx = i_ram_addr[15:2];

  always_comb
  begin
    case (i_ram_size)
      HSIZE_BYTE: byte_en = 4'b0001 << i_ram_addr[1:0];
      HSIZE_HALF: byte_en = i_ram_addr[1] ? 4'b1100 : 4'b0011;
      HSIZE_WORD: byte_en = 4'b1111;
      default:    byte_en = 4'b0000;
    endcase
  end

  always_ff @(posedge i_sys_hclk)
  begin
    if (i_ram_sel && i_ram_write)
    begin
      for (int k = 0; k < 4; k++)
      begin
        if (byte_en[k])
          mem[word_idx][8*k +: 8] <= i_ram_wdata[8*k +: 8];
      end
    end
    if (i_ram_sel && !i_ram_write)
      rd_q <= mem[word_idx];
  end

  always_ff @(posedge i_sys_hclk or negedge i_sys_rst_b)
  begin
    if (!i_sys_rst_b)
      sel_q <= 1'b0;
    else
      sel_q <= i_ram_sel;
  end

  // no data out after an unselected cycle
  assign o_ram_rdata = sel_q ? rd_q : '0;

endmodule

// File: verilog/sms_bank_top.sv
//////////////////////////////////////////////////
// sms 64 KB bank
// deny gate, AHB slave, lane swap and sram stages
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sms_bank_top (
  input  logic              i_sys_hclk,
  input  logic              i_sys_rst_b,
  input  logic              i_hsel,
  input  sms_pkg::haddr_t   i_haddr,
  input  sms_pkg::htrans_e  i_htrans,
  input  sms_pkg::hsize_e   i_hsize,
  input  logic              i_hwrite,
  input  sms_pkg::hdata_t   i_hwdata,
  input  logic              i_big_endian_b,
  input  logic              i_rd_deny,
  input  logic              i_wr_deny,
  output sms_pkg::hdata_t   o_hrdata,
  output logic              o_hready,
  output sms_pkg::hresp_e   o_hresp,
  output logic              o_idle
);
  import sms_pkg::*;

  logic       xfer;
  logic       slv_hready;
  logic       ram_sel;
  logic       ram_write;
  hsize_e     ram_size;
  ram_addr_t  ram_addr;
  hdata_t     ram_wdata;
  hdata_t     ram_rdata;
  logic       dphase;
  hsize_e     dp_size;
  logic [1:0] dp_lane;

  sms_deny_gate u_deny_gate (
    .i_sys_hclk   (i_sys_hclk),
    .i_sys_rst_b  (i_sys_rst_b),
    .i_hsel       (i_hsel),
    .i_htrans     (i_htrans),
    .i_hwrite     (i_hwrite),
    .i_rd_deny    (i_rd_deny),
    .i_wr_deny    (i_wr_deny),
    .i_slv_hready (slv_hready),
    .o_xfer       (xfer),
    .o_hready     (o_hready),
    .o_hresp      (o_hresp)
  );

  sms_ahb_slave u_ahb_slave (
    .i_sys_hclk  (i_sys_hclk),
    .i_sys_rst_b (i_sys_rst_b),
    .i_xfer      (xfer),
    .i_haddr     (i_haddr),
    .i_hsize     (i_hsize),
    .i_hwrite    (i_hwrite),
    .o_hready    (slv_hready),
    .o_ram_sel   (ram_sel),
    .o_ram_write (ram_write),
    .o_ram_size  (ram_size),
    .o_ram_addr  (ram_addr),
    .o_dphase    (dphase),
    .o_dp_size   (dp_size),
    .o_dp_lane   (dp_lane),
    .o_idle      (o_idle)
  );

  sms_lane_swap u_lane_swap (
    .i_big_endian_b (i_big_endian_b),
    .i_dphase       (dphase),
    .i_dp_size      (dp_size),
    .i_dp_lane      (dp_lane),
    .i_hwdata       (i_hwdata),
    .i_ram_rdata    (ram_rdata),
    .o_ram_wdata    (ram_wdata),
    .o_hrdata       (o_hrdata)
  );

  sms_sram_bank u_sram_bank (
    .i_sys_hclk  (i_sys_hclk),
    .i_sys_rst_b (i_sys_rst_b),
    .i_ram_sel   (ram_sel),
    .i_ram_write (ram_write),
    .i_ram_size  (ram_size),
    .i_ram_addr  (ram_addr),
    .i_ram_wdata (ram_wdata),
    .o_ram_rdata (ram_rdata)
  );

endmodule

// File: tb/tb_clk_gen.sv
//////////////////////////////////////////////////
// testbench clock and reset source
// 10 ns clock, reset held low for 4 cycles
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_b
);

  initial
  begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
  end

  initial
  begin
    o_rst_b = 1'b0;
    repeat (4) @(posedge o_clk);
    // release away from the active edge
    @(negedge o_clk);
    o_rst_b = 1'b1;
  end

endmodule

// File: tb/sms_bank_checker.sv
//////////////////////////////////////////////////
// sms bank response protocol checker
// ERROR shape, legal hresp, single wait states
//////////////////////////////////////////////////
`timescale 1ns/1ps

module sms_bank_checker (
  input logic            i_sys_hclk,
  input logic            i_sys_rst_b,
  input logic            i_hready,
  input sms_pkg::hresp_e i_hresp,
  input logic            i_idle
);
  import sms_pkg::*;

  // two-cycle ERROR response, wait then done
  assert property (@(posedge i_sys_hclk) disable iff (!i_sys_rst_b)
    (i_hresp == HRESP_ERROR && !i_hready) |=> (i_hresp == HRESP_ERROR && i_hready))
    else $error("ERROR wait cycle not followed by ERROR with hready high");

  assert property (@(posedge i_sys_hclk) disable iff (!i_sys_rst_b)
    i_hresp inside {HRESP_OKAY, HRESP_ERROR})
    else $error("hresp holds an encoding other than OKAY or ERROR");

  // every stall in this bank is a single cycle
  assert property (@(posedge i_sys_hclk) disable iff (!i_sys_rst_b)
    !i_hready |=> i_hready)
    else $error("hready low for two cycles in a row");

  assert property (@(posedge i_sys_hclk)
    $rose(i_sys_rst_b) |-> (i_hready && i_idle))
    else $error("bank not ready and idle in the first cycle after reset");

endmodule

bind sms_bank_top sms_bank_checker u_checker (
  .i_sys_hclk  (i_sys_hclk),
  .i_sys_rst_b (i_sys_rst_b),
  .i_hready    (o_hready),
  .i_hresp     (o_hresp),
  .i_idle      (o_idle)
);

// File: tb/tb_sms_bank.sv
//////////////////////////////////////////////////
// sms bank testbench
// random AHB traffic against a byte-array model
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_sms_bank;
  import sms_pkg::*;

  localparam int TEST_CYCLES = 600;

  logic clk, rst_b, hsel, hwrite, big_endian_b, rd_deny, wr_deny, hready, idle;
  haddr_t haddr;
  htrans_e htrans;
  hsize_e hsize;
  hdata_t hwdata, hrdata;
  hresp_e hresp;
  logic [7:0] ref_mem [65536];
  logic [31:0] lfsr_q = 32'hc6fa_8e8e;
  int errors = 0, err_mark = 0, n_pass = 0, n_fail = 0;

  tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst_b(rst_b));

  sms_bank_top i_dut (
    .i_sys_hclk(clk), .i_sys_rst_b(rst_b), .i_hsel(hsel), .i_haddr(haddr),
    .i_htrans(htrans), .i_hsize(hsize), .i_hwrite(hwrite), .i_hwdata(hwdata),
    .i_big_endian_b(big_endian_b), .i_rd_deny(rd_deny), .i_wr_deny(wr_deny),
    .o_hrdata(hrdata), .o_hready(hready), .o_hresp(hresp), .o_idle(idle)
  );

  // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [15:0] rand_word_addr();
    logic [31:0] v;
    v = rand_bits(14);
    return {v[13:0], 2'b00};
  endfunction

  function automatic logic lane_on(input logic [15:0] a, input hsize_e sz, input int k);
    if (sz == HSIZE_BYTE)
      return (k == int'(a[1:0]));
    if (sz == HSIZE_HALF)
      return (k / 2 == int'(a[1]));
    return 1'b1;
  endfunction

  // bus lane that pairs with RAM lane k in big-endian mode
  function automatic int bus_lane(input hsize_e sz, input int k);
    if (!big_endian_b && sz == HSIZE_BYTE)
      return 3 - k;
    if (!big_endian_b && sz == HSIZE_HALF)
      return k ^ 2;
    return k;
  endfunction

  task automatic model_write(input logic [15:0] a, input hsize_e sz, input hdata_t d);
    for (int k = 0; k < 4; k++)
      if (lane_on(a, sz, k))
        ref_mem[{a[15:2], 2'(k)}] = d[8*bus_lane(sz, k) +: 8];
  endtask

  function automatic hdata_t predict(input logic [15:0] a, input hsize_e sz);
    hdata_t r;
    r = '0;
    for (int k = 0; k < 4; k++)
      // little-endian reads return the whole word
      if (big_endian_b || sz == HSIZE_WORD || lane_on(a, sz, k))
        r[8*bus_lane(sz, k) +: 8] = ref_mem[{a[15:2], 2'(k)}];
    return r;
  endfunction

  task automatic start_addr(input logic wr, input hsize_e sz, input logic [15:0] a);
    hsel = 1'b1;
    htrans = HTRANS_NONSEQ;
    hwrite = wr;
    hsize = sz;
    haddr = {16'h0000, a};
  endtask

  task automatic go_idle();
    hsel = 1'b0;
    htrans = HTRANS_IDLE;
    rd_deny = 1'b0;
    wr_deny = 1'b0;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic check_rdata(input hdata_t exp);
    assert (hrdata === exp)
    else
    begin
      $display("error o_hrdata expected %h got %h", exp, hrdata);
      errors++;
    end
  endtask

  task automatic do_write(input hsize_e sz, input logic [15:0] a, input hdata_t d);
    start_addr(1'b1, sz, a);
    next_cycle();
    go_idle();
    hwdata = d;
    model_write(a, sz, d);
    while (!hready)
      next_cycle();
    next_cycle();
  endtask

  task automatic do_read(input hsize_e sz, input logic [15:0] a);
    start_addr(1'b0, sz, a);
    next_cycle();
    go_idle();
    while (!hready)
      next_cycle();
    check_rdata(predict(a, sz));
    next_cycle();
  endtask

  // read address issued in the data phase of the write
  task automatic write_then_read(input logic [15:0] wa, input logic [15:0] ra, input hdata_t d);
    int stalls;
    stalls = 0;
    start_addr(1'b1, HSIZE_WORD, wa);
    next_cycle();
    hwdata = d;
    model_write(wa, HSIZE_WORD, d);
    start_addr(1'b0, HSIZE_WORD, ra);
    next_cycle();
    go_idle();
    while (!hready && stalls < 4)
    begin
      stalls++;
      next_cycle();
    end
    assert (stalls == 1)
    else
    begin
      $display("read after write gave %0d wait states instead of one", stalls);
      errors++;
    end
    check_rdata(predict(ra, HSIZE_WORD));
    next_cycle();
  endtask

  task automatic denied_xfer(input logic wr, input logic [15:0] a);
    start_addr(wr, HSIZE_WORD, a);
    wr_deny = wr;
    rd_deny = !wr;
    next_cycle();
    go_idle();
    hwdata = rand_bits(32);
    assert (hresp == HRESP_ERROR && !hready)
    else
    begin
      $display("denied transfer did not start with ERROR and a wait state");
      errors++;
    end
    next_cycle();
    assert (hresp == HRESP_ERROR && hready)
    else
    begin
      $display("denied transfer did not end with ERROR and hready high");
      errors++;
    end
    next_cycle();
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark)
    begin
      $display("test %s: ok", name);
      n_pass++;
    end
    else
    begin
      $display("test %s: failed", name);
      n_fail++;
    end
    err_mark = errors;
  endtask

  initial
  begin
    #(TEST_CYCLES * 10 + 500);
    $display("watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    logic [15:0] a;
    logic [15:0] addrs [8];
    logic [15:0] sub_a;
    hsize_e sub_sz;
    hdata_t d;
    hsel = 1'b0;
    htrans = HTRANS_IDLE;
    hwrite = 1'b0;
    hsize = HSIZE_WORD;
    haddr = '0;
    hwdata = '0;
    big_endian_b = 1'b1;
    rd_deny = 1'b0;
    wr_deny = 1'b0;
    @(posedge rst_b);
    @(negedge clk);

    for (int i = 0; i < 8; i++)
    begin
      addrs[i] = rand_word_addr();
      do_write(HSIZE_WORD, addrs[i], rand_bits(32));
    end
    for (int i = 0; i < 8; i++)
      do_read(HSIZE_WORD, addrs[i]);
    end_test("word write and read back");

    a = rand_word_addr();
    do_write(HSIZE_WORD, a, rand_bits(32));
    do_write(HSIZE_BYTE, a + 16'd1, rand_bits(32));
    do_write(HSIZE_HALF, a + 16'd2, rand_bits(32));
    do_read(HSIZE_WORD, a);
    do_read(HSIZE_BYTE, a + 16'd1);
    end_test("little-endian sub-word merge");

    // bytes on all four lanes, then halfwords at both offsets
    for (int k = 0; k < 6; k++)
    begin
      a = rand_word_addr();
      sub_sz = (k < 4) ? HSIZE_BYTE : HSIZE_HALF;
      sub_a = a + 16'((k < 4) ? k : (k - 4) * 2);
      do_write(HSIZE_WORD, a, rand_bits(32));
      big_endian_b = 1'b0;
      d = rand_bits(32);
      do_write(sub_sz, sub_a, d);
      do_read(sub_sz, sub_a);
      big_endian_b = 1'b1;
      do_read(HSIZE_WORD, a);
    end
    end_test("big-endian lane swap");

    a = rand_word_addr();
    write_then_read(a, a, rand_bits(32));
    write_then_read(a + 16'd4, a, rand_bits(32));
    end_test("read after write stall");

    a = rand_word_addr();
    do_write(HSIZE_WORD, a, rand_bits(32));
    denied_xfer(1'b1, a);
    do_read(HSIZE_WORD, a);
    denied_xfer(1'b0, a);
    end_test("region deny");

    repeat (2) next_cycle();
    assert (idle)
    else
    begin
      $display("bank not idle on a quiet bus");
      errors++;
    end
    start_addr(1'b0, HSIZE_WORD, a);
    #1;
    assert (!idle)
    else
    begin
      $display("bank reports idle while taking a transfer");
      errors++;
    end
    next_cycle();
    go_idle();
    check_rdata(predict(a, HSIZE_WORD));
    next_cycle();
    end_test("idle indication");

    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: verilog.f
verilog/sms_pkg.sv
verilog/sms_deny_gate.sv
verilog/sms_ahb_slave.sv
verilog/sms_lane_swap.sv
verilog/sms_sram_bank.sv
verilog/sms_bank_top.sv
tb/tb_clk_gen.sv
tb/sms_bank_checker.sv
tb/tb_sms_bank.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the sms bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_sms_bank -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1
